// File: verification/ram_stim.txt
// Columns: op (0 read, 1 write, 2 clear), address, write data, expected read data
// All values hex, one operation per line
0 000 00 00
0 7ff 00 00
0 405 00 00
1 005 a5 00
0 005 00 a5
1 405 3c 00
0 005 00 a5
0 405 00 3c
1 3ff 5a 00
1 7ff c3 00
0 3ff 00 5a
0 7ff 00 c3
1 123 81 00
1 523 7e 00
2 000 00 00
0 005 00 00
0 405 00 00
0 3ff 00 00
0 7ff 00 00
1 123 99 00
0 123 00 99
0 523 00 00

// File: filelist.f
src/ram_pkg.sv
src/am9150.sv
src/ram_chip_bank.sv
src/ram_clear_sequencer.sv
src/ram_controller.sv
src/ram_subsystem_top.sv
verification/ram_subsystem_properties.sv
verification/ram_subsystem_tb.sv

// File: Makefile
TOP := ram_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: verification/ram_subsystem_tb.sv
//********************
// Testbench for the memory board top
// Plays the operations of the stim file in order and checks every result
// Random response stalls from an LFSR, run bounded by a cycle limit
//********************
`default_nettype none

module ram_subsystem_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_W    = ram_pkg::CHIP_ADDR_W + 1;   // Two chip rows
   localparam int DATA_W    = 2 * ram_pkg::CHIP_DATA_W;   // Two chip columns
   localparam int MAX_LINES = 64;

   logic              clk = 1'b0;
   logic              RESET_n;
   logic              req_valid;
   logic              req_ready;
   ram_pkg::ram_op_t  req_op;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              rsp_valid;
   logic              rsp_ready;
   logic [DATA_W-1:0] rsp_data;

   logic [11:0] stim [4*MAX_LINES];   // Op, address, data, expected per line
   logic [15:0] lfsr = 16'd1299;      // Back-pressure source
   int unsigned cycles = 0;
   int unsigned limit = 0;
   int          n_lines;
   int          n_clears;

   ram_subsystem_top ram_subsystem_top_i (
      .clk       (clk),
      .RESET_n   (RESET_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data)
   );

   always #2 clk = ~clk;   // 4 ns period

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Verification failed");
         $fatal(1, "Timeout, the run went past %0d cycles", limit);
      end
   end

   // Galois LFSR, taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         $display("Verification failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Inputs change 1 ns after the edge, outputs are settled there
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Hold one request until the edge that takes it
   task automatic send_request(input ram_pkg::ram_op_t op, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = data;
      while (!req_ready) begin
         next_cycle();
      end
      next_cycle();   // Accepted on this edge
      req_valid = 1'b0;
   endtask

   // Edges until the request port opens again
   task automatic wait_ready(input int expected);
      int lat;
      lat = 0;
      while (!req_ready) begin
         check_value("rsp_valid", 32'(rsp_valid), 32'd0);   // No response for write or clear
         next_cycle();
         lat++;
      end
      check_value("ready_latency", lat, expected);
   endtask

   // Read response, taken under random stalls
   task automatic take_response(input logic [DATA_W-1:0] expected);
      int   lat;
      logic taken;
      lat   = 0;
      taken = 1'b0;
      while (!rsp_valid) begin
         next_cycle();
         lat++;
      end
      check_value("read_latency", lat, 32'd2);   // Latch edge, then capture edge
      while (!taken) begin
         check_value("req_ready", 32'(req_ready), 32'd0);        // Blocked while pending
         check_value("rsp_data", 32'(rsp_data), 32'(expected));
         rsp_ready = !lfsr[0];       // Stall when the bit is set
         lfsr      = lfsr_step(lfsr);
         taken     = rsp_ready;
         next_cycle();
      end
      rsp_ready = 1'b0;
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);   // Delivered once
      check_value("req_ready", 32'(req_ready), 32'd1);
   endtask

   initial begin
      ram_pkg::ram_op_t op;
      RESET_n   = 1'b0;
      req_valid = 1'b0;
      req_op    = ram_pkg::OP_READ;
      req_addr  = '0;
      req_wdata = '0;
      rsp_ready = 1'b0;
      for (int i = 0; i < 4*MAX_LINES; i++) begin
         stim[i] = 12'hFFF;   // End marker where the file has no line
      end
      $readmemh("verification/ram_stim.txt", stim);
      n_lines  = 0;
      n_clears = 0;
      while (n_lines < MAX_LINES && stim[4*n_lines] != 12'hFFF) begin
         if (stim[4*n_lines] == 12'(ram_pkg::OP_CLEAR)) begin
            n_clears++;
         end
         n_lines++;
      end
      if (n_lines == 0) begin
         $display("Verification failed");
         $fatal(1, "The stim file holds no operations");
      end
      limit = (n_clears + 1) * 1100 + 20 * n_lines;   // Reset clear counts as one

      repeat (8) next_cycle();
      check_value("req_ready", 32'(req_ready), 32'd0);
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
      RESET_n = 1'b1;
      wait_ready(ram_pkg::CHIP_DEPTH + 1);   // Start cycle plus one write per address

      for (int i = 0; i < n_lines; i++) begin
         op = ram_pkg::ram_op_t'(stim[4*i][1:0]);
         send_request(op, stim[4*i+1][ADDR_W-1:0], stim[4*i+2][DATA_W-1:0]);
         case (op)
            ram_pkg::OP_READ:  take_response(stim[4*i+3][DATA_W-1:0]);
            ram_pkg::OP_WRITE: wait_ready(1);
            default:           wait_ready(ram_pkg::CHIP_DEPTH + 1);
         endcase
      end

      $display("Verification passed");
      $finish;
   end

endmodule : ram_subsystem_tb

`default_nettype wire

// File: verification/ram_subsystem_properties.sv
//********************
// Concurrent checks on the controller handshakes and chip strobes
// Attached to every ram_controller by the bind at the end
//********************
`default_nettype none

module ram_subsystem_properties #(
   parameter int DATA_W = 8
) (
   input wire logic              clk,
   input wire logic              RESET_n,
   input wire logic              req_ready,
   input wire logic              rsp_valid,
   input wire logic              rsp_ready,
   input wire logic [DATA_W-1:0] rsp_data,
   input wire logic              clr_busy,
   input wire logic              write_n,
   input wire logic              output_en_n
);
   timeunit 1ns;
   timeprecision 100ps;

   // Stalled response stays put
   rsp_held: assert property (@(posedge clk) disable iff (!RESET_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
      else $error("Response changed or vanished while stalled");

   // Host locked out during the sweep
   clear_blocks_req: assert property (@(posedge clk) disable iff (!RESET_n)
      clr_busy |-> !req_ready)
      else $error("Request port open during a clear");

   strobes_exclusive: assert property (@(posedge clk) disable iff (!RESET_n)
      !(!write_n && !output_en_n))
      else $error("Write and output enable active together");

endmodule : ram_subsystem_properties

bind ram_controller ram_subsystem_properties #(.DATA_W(DATA_W)) ram_subsystem_properties_i (
   .clk         (clk),
   .RESET_n     (RESET_n),
   .req_ready   (req_ready),
   .rsp_valid   (rsp_valid),
   .rsp_ready   (rsp_ready),
   .rsp_data    (rsp_data),
   .clr_busy    (clr_busy),
   .write_n     (write_n),
   .output_en_n (output_en_n)
);

`default_nettype wire

// File: src/ram_subsystem_top.sv
//********************
// Memory board top, 2048 x 8 by default
// Host valid/ready ports in, controller, clear sweep and chip array inside
//********************
`default_nettype none

module ram_subsystem_top #(
   parameter  int ROWS   = 2,                                    // Chip rows, power of two
   parameter  int COLS   = 2,                                    // Chip columns
   localparam int ROW_W  = $clog2(ROWS),
   localparam int ADDR_W = ram_pkg::CHIP_ADDR_W + ROW_W,
   localparam int DATA_W = COLS * ram_pkg::CHIP_DATA_W
) (
   input  wire logic              clk,
   input  wire logic              RESET_n,
   input  wire logic              req_valid,
   output      logic              req_ready,
   input  wire ram_pkg::ram_op_t  req_op,
   input  wire logic [ADDR_W-1:0] req_addr,
   input  wire logic [DATA_W-1:0] req_wdata,
   output      logic              rsp_valid,
   input  wire logic              rsp_ready,
   output      logic [DATA_W-1:0] rsp_data
);

   // Controller to sequencer
   logic                             clr_start;
   logic                             clr_busy;
   logic [ram_pkg::CHIP_ADDR_W-1:0]  clr_addr;
   logic                             clr_last;

   // Controller to bank
   logic [ram_pkg::CHIP_ADDR_W-1:0]  chip_addr;
   logic [ROW_W-1:0]                 row_sel;
   logic                             select_all;
   logic                             write_n;
   logic                             output_en_n;
   logic [DATA_W-1:0]                wdata;
   logic [DATA_W-1:0]                rdata;

   ram_controller #(.ROWS(ROWS), .COLS(COLS)) ram_controller_i (
      .clk, .RESET_n,
      .req_valid, .req_ready, .req_op, .req_addr, .req_wdata,
      .rsp_valid, .rsp_ready, .rsp_data,
      .clr_start, .clr_busy, .clr_addr, .clr_last,
      .chip_addr, .row_sel, .select_all, .write_n, .output_en_n, .wdata, .rdata
   );

   ram_clear_sequencer ram_clear_sequencer_i (
      .clk, .RESET_n, .clr_start, .clr_busy, .clr_addr, .clr_last
   );

   ram_chip_bank #(.ROWS(ROWS), .COLS(COLS)) ram_chip_bank_i (
      .clk, .RESET_n,
      .chip_addr, .row_sel, .select_all, .write_n, .output_en_n, .wdata, .rdata
   );

endmodule : ram_subsystem_top

`default_nettype wire

// File: src/ram_controller.sv
//********************
// Request/response control for the chip bank
// One request in flight, chip strobes driven from the FSM state
// A clear is started on its own after reset and on OP_CLEAR
//********************
`default_nettype none

module ram_controller #(
   parameter  int ROWS   = 2,
   parameter  int COLS   = 2,
   localparam int ROW_W  = $clog2(ROWS),
   localparam int ADDR_W = ram_pkg::CHIP_ADDR_W + ROW_W,
   localparam int DATA_W = COLS * ram_pkg::CHIP_DATA_W
) (
   input  wire logic                             clk,
   input  wire logic                             RESET_n,
   // Host request port
   input  wire logic                             req_valid,
   output      logic                             req_ready,
   input  wire ram_pkg::ram_op_t                 req_op,
   input  wire logic [ADDR_W-1:0]                req_addr,
   input  wire logic [DATA_W-1:0]                req_wdata,
   // Host response port
   output      logic                             rsp_valid,
   input  wire logic                             rsp_ready,
   output      logic [DATA_W-1:0]                rsp_data,
   // Clear sequencer
   output      logic                             clr_start,
   input  wire logic                             clr_busy,
   input  wire logic [ram_pkg::CHIP_ADDR_W-1:0]  clr_addr,
   input  wire logic                             clr_last,
   // Chip bank
   output      logic [ram_pkg::CHIP_ADDR_W-1:0]  chip_addr,
   output      logic [ROW_W-1:0]                 row_sel,
   output      logic                             select_all,
   output      logic                             write_n,
   output      logic                             output_en_n,
   output      logic [DATA_W-1:0]                wdata,
   input  wire logic [DATA_W-1:0]                rdata
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_CLEARING,    // Sequencer sweeping, all rows written with zero
      S_WRITING,     // One write strobe
      S_READING,     // Chips latch the word
      S_RESPONDING   // Capture, then hold until consumed
   } state_t;

   state_t state;
   state_t state_nxt;

   logic              accept;
   logic [ADDR_W-1:0] addr_q;    // Accepted request
   logic [DATA_W-1:0] wdata_q;

   assign req_ready = (state == S_IDLE);
   assign accept    = req_valid && req_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (accept) begin
               case (req_op)
                  ram_pkg::OP_READ:  state_nxt = S_READING;
                  ram_pkg::OP_WRITE: state_nxt = S_WRITING;
                  ram_pkg::OP_CLEAR: state_nxt = S_CLEARING;
                  default:           state_nxt = S_IDLE;    // Unknown op dropped
               endcase
            end
         end
         S_CLEARING:   if (clr_last) state_nxt = S_IDLE;
         S_WRITING:    state_nxt = S_IDLE;
         S_READING:    state_nxt = S_RESPONDING;
         S_RESPONDING: if (rsp_valid && rsp_ready) state_nxt = S_IDLE;
         default:      state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!RESET_n) begin
         state     <= S_CLEARING;   // Board comes up with a clear
         clr_start <= 1'b1;         // Kick the sweep in the first cycle after reset
         rsp_valid <= 1'b0;
      end else begin
         state     <= state_nxt;
         clr_start <= accept && (req_op == ram_pkg::OP_CLEAR);
         if (state == S_RESPONDING && !rsp_valid) begin
            rsp_valid <= 1'b1;      // Word captured this edge
         end else if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
      end
      if (state == S_RESPONDING && !rsp_valid) begin
         rsp_data <= rdata;         // Held while the host stalls
      end
   end

   // Chip strobes
   assign select_all  = (state == S_CLEARING);
   assign chip_addr   = select_all ? clr_addr : addr_q[ram_pkg::CHIP_ADDR_W-1:0];
   assign row_sel     = addr_q[ADDR_W-1 -: ROW_W];                  // Top bits pick the row
   assign write_n     = !((state == S_WRITING) || (select_all && clr_busy));
   assign output_en_n = !((state == S_READING) || (state == S_RESPONDING));
   assign wdata       = select_all ? '0 : wdata_q;                  // Zero fill on clear

endmodule : ram_controller

`default_nettype wire

// File: src/ram_clear_sequencer.sv
//********************
// Address sweep for the board clear
// A start pulse walks every chip address once, one per cycle
//********************
`default_nettype none

module ram_clear_sequencer (
   input  wire logic                             clk,
   input  wire logic                             RESET_n,
   input  wire logic                             clr_start,  // One-cycle pulse
   output      logic                             clr_busy,
   output      logic [ram_pkg::CHIP_ADDR_W-1:0]  clr_addr,
   output      logic                             clr_last    // Final address of the sweep
);

   localparam logic [ram_pkg::CHIP_ADDR_W-1:0] LAST_ADDR =
      ram_pkg::CHIP_ADDR_W'(ram_pkg::CHIP_DEPTH - 1);

   always_ff @(posedge clk) begin
      if (!RESET_n) begin
         clr_busy <= 1'b0;
         clr_addr <= '0;
      end else if (clr_start) begin
         clr_busy <= 1'b1;                 // Restart from address zero
         clr_addr <= '0;
      end else if (clr_busy) begin
         if (clr_addr == LAST_ADDR) begin
            clr_busy <= 1'b0;              // Sweep done
         end else begin
            clr_addr <= clr_addr + 1'b1;
         end
      end
   end

   assign clr_last = clr_busy && (clr_addr == LAST_ADDR);

endmodule : ram_clear_sequencer

`default_nettype wire

// File: src/ram_chip_bank.sv
//********************
// Board array of ROWS x COLS Am9150 chips
// Row select decode with a select-all path for the clear sweep
// Columns split the data word, rows are merged by OR
//********************
`default_nettype none

module ram_chip_bank #(
   parameter  int ROWS   = 2,                                // Power of two
   parameter  int COLS   = 2,
   localparam int ROW_W  = $clog2(ROWS),
   localparam int DATA_W = COLS * ram_pkg::CHIP_DATA_W
) (
   input  wire logic                             clk,
   input  wire logic                             RESET_n,
   input  wire logic [ram_pkg::CHIP_ADDR_W-1:0]  chip_addr,   // Shared by every chip
   input  wire logic [ROW_W-1:0]                 row_sel,
   input  wire logic                             select_all,  // Clear sweep, all rows at once
   input  wire logic                             write_n,
   input  wire logic                             output_en_n,
   input  wire logic [DATA_W-1:0]                wdata,
   output      logic [DATA_W-1:0]                rdata
);

   localparam int DW = ram_pkg::CHIP_DATA_W;

   logic [ROWS-1:0]   chip_sel_n;           // One active-low select per row
   logic [DATA_W-1:0] row_rdata [ROWS];     // Gated output of each row

   genvar r;
   genvar c;

   generate
      for (r = 0; r < ROWS; r++) begin : g_row
         // Row decode
         assign chip_sel_n[r] = !(select_all || (row_sel == ROW_W'(r)));

         for (c = 0; c < COLS; c++) begin : g_col
            am9150 am9150_i (
               .clk             (clk),
               .RESET_n         (RESET_n),
               .address         (chip_addr),
               .data_in         (wdata[c*DW +: DW]),         // Column slice
               .data_out        (row_rdata[r][c*DW +: DW]),
               .write_enable_n  (write_n),
               .chip_select_n   (chip_sel_n[r]),
               .output_enable_n (output_en_n)
            );
         end
      end
   endgenerate

   // Wired-OR of the row outputs, unselected rows read as zero
   always_comb begin
      rdata = '0;
      for (int i = 0; i < ROWS; i++) begin
         rdata = rdata | row_rdata[i];
      end
   end

endmodule : ram_chip_bank

`default_nettype wire

// File: src/am9150.sv
//********************
// Behavioral model of one Am9150 1024x4 static RAM
// Separate data in and out, active-low select, write and output enable
// Output reads as zero when not driven so rows can be merged by OR
//********************
`default_nettype none

module am9150 (
   input  wire logic                             clk,
   input  wire logic                             RESET_n,         // /R, gates the output only
   input  wire logic [ram_pkg::CHIP_ADDR_W-1:0]  address,
   input  wire logic [ram_pkg::CHIP_DATA_W-1:0]  data_in,
   output      logic [ram_pkg::CHIP_DATA_W-1:0]  data_out,
   input  wire logic                             write_enable_n,  // /W
   input  wire logic                             chip_select_n,   // /S
   input  wire logic                             output_enable_n  // /G
);

   // Cell array, maps to block RAM
   logic [ram_pkg::CHIP_DATA_W-1:0] mem [ram_pkg::CHIP_DEPTH];

   logic [ram_pkg::CHIP_DATA_W-1:0] data_reg;  // Output latch

   // Selected chip either writes or latches the addressed word
   always_ff @(posedge clk) begin
      if (!chip_select_n) begin
         if (!write_enable_n) begin
            mem[address] <= data_in;   // Write cycle
         end else begin
            data_reg <= mem[address];  // Read cycle
         end
      end
   end

   // Outputs float while deselected, disabled, writing or in reset
   // Zero stands in for high impedance on the board
   assign data_out = (!chip_select_n && !output_enable_n && write_enable_n && RESET_n)
                     ? data_reg : '0;

endmodule : am9150

`default_nettype wire

// File: src/ram_pkg.sv
//********************
// Shared definitions for the Am9150 memory board model
// Operation codes of the host request port and the fixed chip geometry
// Referenced by scoped name from the RTL and the testbench
//********************
`default_nettype none

package ram_pkg;

   // Host request operations
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,   // Read one byte, answered on the response port
      OP_WRITE = 2'd1,   // Write one byte, no response
      OP_CLEAR = 2'd2    // Zero the whole store, no response
   } ram_op_t;

   // Am9150 organization, 1024 words of 4 bits
   parameter int CHIP_ADDR_W = 10;    // A0..A9
   parameter int CHIP_DATA_W = 4;     // D0..D3 / Q0..Q3
   parameter int CHIP_DEPTH  = 1024;  // Words per chip

endpackage : ram_pkg

`default_nettype wire
